// ==== Makefile ====
# Verilator build and run for the operand forwarding core

VERILATOR  ?= verilator
TOP        ?= opfwd_tb
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FILELIST   ?= project.f
EXTRA_ARGS ?=

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --assert $(EXTRA_ARGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/opfwd_sva.sv ====
/* opfwd_sva: bound checks on issue stall, x0 scoreboard bit and the fixed
   accept to retire latency of the operand forwarding core */
`timescale 1ns/1ps

module opfwd_sva (
  input logic                  clk,
  input logic                  arst_n,
  input opfwd_pkg::issue_req_t req,
  input logic                  stall,
  input logic                  accept,
  input logic                  x0_pending,
  input logic                  retire_valid
);

  // stall only holds back a real request, and the load-use bubble
  // lets the held request go on the next cycle
  a_stall_valid_and_short: assert property (
    @(posedge clk) disable iff (!arst_n) stall |-> req.valid ##1 !stall
  ) else $error("stall raised without a valid request or held past one cycle");

  a_x0_never_pending: assert property (
    @(posedge clk) disable iff (!arst_n) !x0_pending
  ) else $error("x0 marked pending in the scoreboard");

  // E, M, W fixed latency
  a_retire_latency: assert property (
    @(posedge clk) disable iff (!arst_n) retire_valid == $past(accept, 3)
  ) else $error("retire does not follow accept by three cycles");

endmodule

bind opfwd_core opfwd_sva i_opfwd_sva (
  .clk          (clk),
  .arst_n       (arst_n),
  .req          (req),
  .stall        (stall),
  .accept       (accept),
  .x0_pending   (i_reg_scoreboard.pending[0]),
  .retire_valid (retire.valid)
);

// ==== dv/opfwd_tb.sv ====
/* opfwd_tb: random instruction stream into the operand forwarding core,
   reference register model and in-order retire checker */
`timescale 1ns/1ps

module opfwd_tb;

  localparam int NUM_INSTR    = 2000;
  localparam int RUN_TIMEOUT  = 40000;  // cycles for the whole stream
  localparam int RETIRE_LIMIT = 4;      // cycles an entry may wait to retire

  logic                  clk;
  logic                  arst_n;
  opfwd_pkg::issue_req_t req;
  logic                  stall;
  opfwd_pkg::wb_port_t   retire;

  opfwd_pkg::xlen_t      model_regs [opfwd_pkg::NUM_REGS];
  opfwd_pkg::issue_req_t pend_q [$];    // accepted, not yet retired
  int                    acc_cyc_q [$];
  opfwd_pkg::reg_addr_t  ldi_in_e;      // rd of an LDI now in E, else 0
  int                    cyc = 0;
  int                    retired = 0;
  int                    idle = 0;

  opfwd_core i_opfwd_core (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .stall  (stall),
    .retire (retire)
  );

  always #10 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "run stopped at first failure");
  endtask

  function automatic opfwd_pkg::reg_addr_t pick_reg();
    logic [31:0] r;
    r = $urandom;
    if (r[31:28] < 4'd14) begin
      return {2'b00, r[2:0]};  // mostly x0..x7, frequent dependencies
    end
    return r[4:0];
  endfunction

  // result of one instruction from the architectural model
  function automatic opfwd_pkg::xlen_t expected_result(opfwd_pkg::issue_req_t ins);
    opfwd_pkg::xlen_t a;
    opfwd_pkg::xlen_t b;
    a = ins.use_rs1 ? model_regs[ins.rs1] : '0;
    b = ins.use_rs2 ? model_regs[ins.rs2] : '0;
    case (ins.op)
      opfwd_pkg::OP_LDI: return ins.imm;
      opfwd_pkg::OP_XOR: return a ^ b;
      default:           return a + b;
    endcase
  endfunction

  // only a load in E can hold back a reader of its rd
  function automatic logic stall_expected();
    logic hit1;
    logic hit2;
    hit1 = req.use_rs1 && (req.rs1 == ldi_in_e);
    hit2 = req.use_rs2 && (req.rs2 == ldi_in_e);
    return req.valid && (ldi_in_e != '0) && (hit1 || hit2);
  endfunction

  task automatic new_request();
    logic [31:0] r;
    r = $urandom;
    req           = '0;
    req.valid     = (r[3:0] != 4'd0);  // occasional idle cycle
    req.op        = (r[5:4] == 2'd3) ? opfwd_pkg::OP_LDI : r[5:4];
    req.writes_rd = (r[9:8] != 2'd0);
    req.rd        = pick_reg();
    req.imm       = $urandom;
    if (req.op == opfwd_pkg::OP_LDI) begin
      req.rs1 = pick_reg();  // unused, may well be pending
      req.rs2 = pick_reg();
    end else begin
      req.use_rs1 = r[10] | r[11];
      req.use_rs2 = r[12] | r[13];
      req.rs1     = req.use_rs1 ? pick_reg() : '0;
      req.rs2     = req.use_rs2 ? pick_reg() : '0;
    end
  endtask

  // retire checker, compares against the oldest accepted instruction
  always @(negedge clk) begin
    opfwd_pkg::issue_req_t head;
    opfwd_pkg::xlen_t      exp_data;
    opfwd_pkg::reg_addr_t  exp_rd;
    int                    acc;
    if (arst_n && retire.valid) begin
      assert (pend_q.size() > 0)
        else report_failure("retire seen with no accepted instruction outstanding");
      head     = pend_q.pop_front();
      acc      = acc_cyc_q.pop_front();
      exp_data = expected_result(head);
      exp_rd   = head.writes_rd ? head.rd : '0;
      assert (cyc == acc + 3)
        else report_failure($sformatf("error retire_timing expected %0d actual %0d",
                                      acc + 3, cyc));
      assert (retire.rd == exp_rd)
        else report_failure($sformatf("error retire_rd expected %0d actual %0d",
                                      exp_rd, retire.rd));
      assert (retire.data == exp_data)
        else report_failure($sformatf("error retire_data expected %08h actual %08h",
                                      exp_data, retire.data));
      if (exp_rd != '0) model_regs[exp_rd] = exp_data;  // x0 stays zero
      retired++;
      idle = 0;
    end else if (pend_q.size() > 0) begin
      idle++;
      assert (idle <= RETIRE_LIMIT)
        else report_failure("accepted instruction did not retire in time");
    end else begin
      idle = 0;
    end
  end

  initial begin
    logic exp_stall;
    logic took;
    int   cycles;
    clk      = 1'b0;
    arst_n   = 1'b0;
    req      = '0;
    ldi_in_e = '0;
    cycles   = 0;
    void'($urandom(80));
    for (int i = 0; i < opfwd_pkg::NUM_REGS; i++) model_regs[i] = '0;
    repeat (8) @(posedge clk);
    #2 arst_n = 1'b1;
    new_request();
    while (retired < NUM_INSTR) begin
      @(negedge clk);
      exp_stall = stall_expected();
      assert (stall == exp_stall)
        else report_failure($sformatf("error stall_check expected %0b actual %0b",
                                      exp_stall, stall));
      took = req.valid && !stall;
      if (took) begin
        pend_q.push_back(req);
        acc_cyc_q.push_back(cyc);
      end
      ldi_in_e = (took && req.writes_rd && (req.op == opfwd_pkg::OP_LDI)) ? req.rd : '0;
      cycles++;
      assert (cycles < RUN_TIMEOUT) else report_failure("timeout before all retires");
      @(posedge clk);
      #2;
      if (!(req.valid && !took)) new_request();
    end
    $display("Verification passed");
    $finish;
  end

endmodule

// ==== hdl/exec_pipe.sv ====
/* exec_pipe: E, M and W stages with the ALU and late LDI result, drives the
   forward ports of each stage and the retire port out of W */
`timescale 1ns/1ps

module exec_pipe (
  input  logic                 clk,
  input  logic                 arst_n,
  input  opfwd_pkg::stage_t    e_entry,
  output opfwd_pkg::fwd_port_t fwd_e,
  output opfwd_pkg::fwd_port_t fwd_m,
  output opfwd_pkg::fwd_port_t fwd_w,
  output opfwd_pkg::wb_port_t  wb
);

  opfwd_pkg::xlen_t     alu_res;
  opfwd_pkg::reg_addr_t e_rd;      // E writer, 0 if none
  opfwd_pkg::reg_addr_t e_ldi_rd;  // E LDI writer, value not ready yet
  logic                 m_valid;
  opfwd_pkg::op_t       m_op;
  opfwd_pkg::reg_addr_t m_rd;      // 0 for bubbles and non-writers
  opfwd_pkg::xlen_t     m_alu;
  opfwd_pkg::xlen_t     m_imm;
  opfwd_pkg::xlen_t     m_res;
  opfwd_pkg::wb_port_t  w_q;

  always_comb begin
    case (e_entry.op)
      opfwd_pkg::OP_XOR: alu_res = e_entry.op1 ^ e_entry.op2;
      default:           alu_res = e_entry.op1 + e_entry.op2;
    endcase
  end

  assign e_rd     = (e_entry.valid && e_entry.writes_rd) ? e_entry.rd : '0;
  assign e_ldi_rd = (e_entry.op == opfwd_pkg::OP_LDI) ? e_rd : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid <= 1'b0;
      m_op    <= opfwd_pkg::OP_ADD;
      m_rd    <= '0;
    end else begin
      m_valid <= e_entry.valid;
      m_op    <= e_entry.op;
      m_rd    <= e_rd;
    end
  end

  always_ff @(posedge clk) begin
    m_alu <= alu_res;
    m_imm <= e_entry.imm;
  end

  assign m_res = (m_op == opfwd_pkg::OP_LDI) ? m_imm : m_alu;  // load data arrives in M

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      w_q <= '0;
    end else begin
      w_q.valid <= m_valid;
      w_q.rd    <= m_rd;
      w_q.data  <= m_res;
    end
  end

  // an LDI in E hides older values of its rd, so a reader stalls
  // instead of picking up a stale M or W value
  always_comb begin
    fwd_e.addr = (e_entry.op == opfwd_pkg::OP_LDI) ? '0 : e_rd;
    fwd_e.data = alu_res;
    fwd_m.addr = (m_rd == e_ldi_rd) ? '0 : m_rd;
    fwd_m.data = m_res;
    fwd_w.addr = (w_q.rd == e_ldi_rd) ? '0 : w_q.rd;
    fwd_w.data = w_q.data;
  end

  assign wb = w_q;  // valid for every W instruction

endmodule

// ==== hdl/forward_arbiter.sv ====
/* forward_arbiter: picks the forward source of each pending operand with
   E over M over W priority, flags a data hazard when none can supply it */
`timescale 1ns/1ps

module forward_arbiter (
  input  logic                 op1_ready,
  input  logic                 op2_ready,
  input  opfwd_pkg::reg_addr_t rs1_addr,
  input  opfwd_pkg::reg_addr_t rs2_addr,
  input  opfwd_pkg::reg_addr_t fwd_e_addr,
  input  opfwd_pkg::reg_addr_t fwd_m_addr,
  input  opfwd_pkg::reg_addr_t fwd_w_addr,
  output logic                 is_data_hazard,
  output opfwd_pkg::fwd_sel_t  rs1_forward_selector,
  output opfwd_pkg::fwd_sel_t  rs2_forward_selector
);

  logic op1_data_hazard;
  logic op2_data_hazard;

  assign is_data_hazard = op1_data_hazard || op2_data_hazard;

  always_comb begin
    rs1_forward_selector = opfwd_pkg::FWD_NONE;
    op1_data_hazard      = 1'b0;
    if (!op1_ready) begin
      // case items are checked in order, E first as the youngest writer
      case (rs1_addr)
        fwd_e_addr: rs1_forward_selector = opfwd_pkg::FWD_E;
        fwd_m_addr: rs1_forward_selector = opfwd_pkg::FWD_M;
        fwd_w_addr: rs1_forward_selector = opfwd_pkg::FWD_W;
        default: begin
          op1_data_hazard = 1'b1;  // producer not far enough yet
        end
      endcase
    end
  end

  always_comb begin
    rs2_forward_selector = opfwd_pkg::FWD_NONE;
    op2_data_hazard      = 1'b0;
    if (!op2_ready) begin
      case (rs2_addr)
        fwd_e_addr: rs2_forward_selector = opfwd_pkg::FWD_E;
        fwd_m_addr: rs2_forward_selector = opfwd_pkg::FWD_M;
        fwd_w_addr: rs2_forward_selector = opfwd_pkg::FWD_W;
        default: begin
          op2_data_hazard = 1'b1;
        end
      endcase
    end
  end

endmodule

// ==== hdl/operand_issue.sv ====
/* operand_issue: selects each source from the register file or a forward
   port, stalls on hazard and loads the E stage register */
`timescale 1ns/1ps

module operand_issue (
  input  logic                  clk,
  input  logic                  arst_n,
  input  opfwd_pkg::issue_req_t req,
  input  logic                  op1_ready,
  input  logic                  op2_ready,
  input  opfwd_pkg::xlen_t      rs1_data,
  input  opfwd_pkg::xlen_t      rs2_data,
  input  opfwd_pkg::fwd_port_t  fwd_e,
  input  opfwd_pkg::fwd_port_t  fwd_m,
  input  opfwd_pkg::fwd_port_t  fwd_w,
  output logic                  stall,
  output logic                  accept,
  output opfwd_pkg::stage_t     e_entry
);

  logic                is_data_hazard;
  opfwd_pkg::fwd_sel_t rs1_sel;
  opfwd_pkg::fwd_sel_t rs2_sel;
  opfwd_pkg::xlen_t    op1_val;
  opfwd_pkg::xlen_t    op2_val;
  opfwd_pkg::stage_t   e_next;

  forward_arbiter i_forward_arbiter (
    .op1_ready            (op1_ready),
    .op2_ready            (op2_ready),
    .rs1_addr             (req.rs1),
    .rs2_addr             (req.rs2),
    .fwd_e_addr           (fwd_e.addr),
    .fwd_m_addr           (fwd_m.addr),
    .fwd_w_addr           (fwd_w.addr),
    .is_data_hazard       (is_data_hazard),
    .rs1_forward_selector (rs1_sel),
    .rs2_forward_selector (rs2_sel)
  );

  assign stall  = req.valid && is_data_hazard;
  assign accept = req.valid && !is_data_hazard;

  always_comb begin
    case (rs1_sel)
      opfwd_pkg::FWD_E: op1_val = fwd_e.data;
      opfwd_pkg::FWD_M: op1_val = fwd_m.data;
      opfwd_pkg::FWD_W: op1_val = fwd_w.data;
      default:          op1_val = rs1_data;
    endcase
    case (rs2_sel)
      opfwd_pkg::FWD_E: op2_val = fwd_e.data;
      opfwd_pkg::FWD_M: op2_val = fwd_m.data;
      opfwd_pkg::FWD_W: op2_val = fwd_w.data;
      default:          op2_val = rs2_data;
    endcase
  end

  always_comb begin
    e_next.valid     = accept;  // bubble when stalled or idle
    e_next.op        = req.op;
    e_next.rd        = req.rd;
    e_next.writes_rd = req.writes_rd;
    e_next.op1       = op1_val;
    e_next.op2       = op2_val;
    e_next.imm       = req.imm;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      e_entry <= '0;
    end else begin
      e_entry <= e_next;
    end
  end

endmodule

// ==== hdl/opfwd_core.sv ====
/* opfwd_core: operand delivery top level, joins scoreboard, register file,
   issue stage and execution pipe */
`timescale 1ns/1ps

module opfwd_core (
  input  logic                  clk,
  input  logic                  arst_n,
  input  opfwd_pkg::issue_req_t req,
  output logic                  stall,
  output opfwd_pkg::wb_port_t   retire
);

  logic                 op1_ready;
  logic                 op2_ready;
  logic                 accept;
  opfwd_pkg::xlen_t     rs1_data;
  opfwd_pkg::xlen_t     rs2_data;
  opfwd_pkg::fwd_port_t fwd_e;
  opfwd_pkg::fwd_port_t fwd_m;
  opfwd_pkg::fwd_port_t fwd_w;
  opfwd_pkg::wb_port_t  wb;
  opfwd_pkg::stage_t    e_entry;

  reg_file i_reg_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (req.rs1),
    .rs2_addr (req.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  reg_scoreboard i_reg_scoreboard (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .accept    (accept),
    .wb        (wb),
    .op1_ready (op1_ready),
    .op2_ready (op2_ready)
  );

  operand_issue i_operand_issue (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .op1_ready (op1_ready),
    .op2_ready (op2_ready),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .fwd_e     (fwd_e),
    .fwd_m     (fwd_m),
    .fwd_w     (fwd_w),
    .stall     (stall),
    .accept    (accept),
    .e_entry   (e_entry)
  );

  exec_pipe i_exec_pipe (
    .clk     (clk),
    .arst_n  (arst_n),
    .e_entry (e_entry),
    .fwd_e   (fwd_e),
    .fwd_m   (fwd_m),
    .fwd_w   (fwd_w),
    .wb      (wb)
  );

  assign retire = wb;

endmodule

// ==== hdl/opfwd_pkg.sv ====
/* opfwd_pkg: widths, forward selector and operation codes, and the packed
   structs shared by the operand forwarding pipeline */
package opfwd_pkg;

  localparam int NUM_REGS = 32;

  typedef logic [4:0]  reg_addr_t;  // register index
  typedef logic [31:0] xlen_t;      // data word
  typedef logic [1:0]  fwd_sel_t;   // operand source select
  typedef logic [1:0]  op_t;        // operation code

  // forward selector codes
  localparam fwd_sel_t FWD_NONE = 2'd0;  // take register file value
  localparam fwd_sel_t FWD_E    = 2'd1;
  localparam fwd_sel_t FWD_M    = 2'd2;
  localparam fwd_sel_t FWD_W    = 2'd3;

  // operation codes
  localparam op_t OP_ADD = 2'd0;
  localparam op_t OP_XOR = 2'd1;
  localparam op_t OP_LDI = 2'd2;  // load model, value ready in M

  // one decoded instruction from the source
  typedef struct packed {
    logic      valid;
    op_t       op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      use_rs1;
    logic      use_rs2;
    reg_addr_t rd;
    logic      writes_rd;
    xlen_t     imm;
  } issue_req_t;

  // value offered by a stage, addr 0 when nothing to offer
  typedef struct packed {
    reg_addr_t addr;
    xlen_t     data;
  } fwd_port_t;

  // committing write out of W
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    xlen_t     data;
  } wb_port_t;

  // entry held in the E stage
  typedef struct packed {
    logic      valid;
    op_t       op;
    reg_addr_t rd;
    logic      writes_rd;
    xlen_t     op1;
    xlen_t     op2;
    xlen_t     imm;
  } stage_t;

endpackage

// ==== hdl/reg_file.sv ====
/* reg_file: 32 x 32-bit register file, two asynchronous read ports and one
   write port fed from writeback, x0 hard-wired to zero */
`timescale 1ns/1ps

module reg_file (
  input  logic                clk,
  input  logic                arst_n,
  input  opfwd_pkg::reg_addr_t rs1_addr,
  input  opfwd_pkg::reg_addr_t rs2_addr,
  output opfwd_pkg::xlen_t    rs1_data,
  output opfwd_pkg::xlen_t    rs2_data,
  input  opfwd_pkg::wb_port_t wb
);

  opfwd_pkg::xlen_t regs [1:opfwd_pkg::NUM_REGS-1];  // x0 has no storage

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < opfwd_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;  // written at end of W
    end
  end

  // no bypass here, same-cycle readers get the W forward instead
  always_comb begin
    rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
  end

endmodule

// ==== hdl/reg_scoreboard.sv ====
/* reg_scoreboard: one pending-write bit per register, reports whether each
   used source of the presented instruction is ready */
`timescale 1ns/1ps

module reg_scoreboard (
  input  logic                  clk,
  input  logic                  arst_n,
  input  opfwd_pkg::issue_req_t req,
  input  logic                  accept,
  input  opfwd_pkg::wb_port_t   wb,
  output logic                  op1_ready,
  output logic                  op2_ready
);

  logic [opfwd_pkg::NUM_REGS-1:0] pending;
  opfwd_pkg::reg_addr_t set_rd;  // 0 when nothing to set
  opfwd_pkg::reg_addr_t e_rd;    // writers now in E and M
  opfwd_pkg::reg_addr_t m_rd;
  logic                 clr_ok;

  assign set_rd = (accept && req.writes_rd) ? req.rd : '0;

  // an older retire must not clear a register that a younger
  // instruction still has in flight
  assign clr_ok = wb.valid && (wb.rd != '0) && (wb.rd != e_rd) && (wb.rd != m_rd);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pending <= '0;
      e_rd    <= '0;
      m_rd    <= '0;
    end else begin
      e_rd <= set_rd;
      m_rd <= e_rd;
      if (clr_ok) begin
        pending[wb.rd] <= 1'b0;
      end
      if (set_rd != '0) begin
        pending[set_rd] <= 1'b1;  // set wins over clear
      end
    end
  end

  // ready means not needed, or needed and not pending
  assign op1_ready = !req.use_rs1 || !pending[req.rs1];
  assign op2_ready = !req.use_rs2 || !pending[req.rs2];

endmodule

// ==== project.f ====
hdl/opfwd_pkg.sv
hdl/reg_file.sv
hdl/reg_scoreboard.sv
hdl/forward_arbiter.sv
hdl/operand_issue.sv
hdl/exec_pipe.sv
hdl/opfwd_core.sv
dv/opfwd_sva.sv
dv/opfwd_tb.sv
